//--- hdl/soqpskPkg.sv
package soqpskPkg;

    // datapath widths
    localparam int DEV_WIDTH      = 18;
    localparam int FIR_WIDTH      = 18;
    localparam int FREQ_WIDTH     = 3;
    localparam int COEF_WIDTH     = 12;
    localparam int NUM_TAPS       = 16;
    localparam int DEV_GAIN_SHIFT = 5;

    // +1/2 deviation in quarter steps
    localparam logic signed [FREQ_WIDTH-1:0] FREQ_HALF = 3'sd2;

    // saturation limits of a deviation sample
    localparam logic signed [DEV_WIDTH-1:0] DEV_MAX = {1'b0, {(DEV_WIDTH-1){1'b1}}};
    localparam logic signed [DEV_WIDTH-1:0] DEV_MIN = {1'b1, {(DEV_WIDTH-1){1'b0}}};

    // symmetric shaping taps
    localparam logic [NUM_TAPS-1:0][COEF_WIDTH-1:0] FIR_COEFS = '{
        -12'sd6,   -12'sd20,  -12'sd15,  12'sd30,
        12'sd125,  12'sd300,  12'sd525,  12'sd700,
        12'sd700,  12'sd525,  12'sd300,  12'sd125,
        12'sd30,   -12'sd15,  -12'sd20,  -12'sd6
    };

    // 2'b10 is never produced
    typedef enum logic [1:0] {
        SYM_ZERO = 2'b00,
        SYM_POS  = 2'b01,
        SYM_NEG  = 2'b11
    } ternSym_t;

    typedef struct packed {
        logic signed [FIR_WIDTH-1:0] sample;
        logic                        valid;
    } chanOut_t;

    typedef struct packed {
        logic signed [DEV_WIDTH-1:0] dev0;
        logic signed [DEV_WIDTH-1:0] dev1;
    } devPair_t;

endpackage

//--- hdl/soqpskTernaryEncoder.sv
`timescale 1ns/100ps

module soqpskTernaryEncoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  logic                bitEn,
    input  logic                dataBit,
    input  logic                dataValid,
    output soqpskPkg::ternSym_t symbol,
    output logic                symbolValid
);
    import soqpskPkg::*;

    // bit history where 1 stands for +1
    logic     prevBit1;
    logic     prevBit2;
    // index of the incoming bit is odd
    logic     bitOdd;
    logic     symNegative;
    ternSym_t nextSymbol;

    always_comb begin
        // sign of (-1)^(k+1) * b[k-1] * b[k]
        symNegative = ~(bitOdd ^ prevBit1 ^ dataBit);
        if (dataBit == prevBit2) begin
            nextSymbol = SYM_ZERO;
        end
        else if (symNegative) begin
            nextSymbol = SYM_NEG;
        end
        else begin
            nextSymbol = SYM_POS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prevBit1    <= 1'b1;
            prevBit2    <= 1'b1;
            bitOdd      <= 1'b0;
            symbol      <= SYM_ZERO;
            symbolValid <= 1'b0;
        end
        else if (clkEn) begin
            if (!dataValid) begin
                // restart the stream at bit 0
                prevBit1    <= 1'b1;
                prevBit2    <= 1'b1;
                bitOdd      <= 1'b0;
                symbol      <= SYM_ZERO;
                symbolValid <= 1'b0;
            end
            else if (bitEn) begin
                symbol      <= nextSymbol;
                symbolValid <= 1'b1;
                prevBit2    <= prevBit1;
                prevBit1    <= dataBit;
                bitOdd      <= ~bitOdd;
            end
        end
    end

    // illegal code never reaches the mapper
    assert property (@(posedge clk) disable iff (reset)
        symbol != 2'b10);

endmodule

//--- hdl/soqpskShapingFir.sv
`timescale 1ns/100ps

module soqpskShapingFir (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   clkEn,
    input  logic                                   sampleEn,
    input  logic                                   clear,
    input  logic signed [soqpskPkg::FREQ_WIDTH-1:0] sampleIn,
    output soqpskPkg::chanOut_t                    filtOut
);
    import soqpskPkg::*;

    localparam int HALF_TAPS  = NUM_TAPS / 2;
    localparam int PRE_WIDTH  = FREQ_WIDTH + 1;
    localparam int PROD_WIDTH = PRE_WIDTH + COEF_WIDTH;

    // stored history behind the incoming sample at tap 0
    logic signed [FREQ_WIDTH-1:0] delayLine [NUM_TAPS-1];
    logic signed [FREQ_WIDTH-1:0] nextTaps  [NUM_TAPS];
    logic signed [PRE_WIDTH-1:0]  preSum    [HALF_TAPS];
    logic signed [PROD_WIDTH-1:0] product   [HALF_TAPS];
    logic signed [FIR_WIDTH-1:0]  accSum;

    always_comb begin
        nextTaps[0] = sampleIn;
        for (int i = 1; i < NUM_TAPS; i++) begin
            nextTaps[i] = delayLine[i-1];
        end
    end

    // symmetric taps share one multiplier
    always_comb begin
        for (int i = 0; i < HALF_TAPS; i++) begin
            preSum[i]  = nextTaps[i] + nextTaps[NUM_TAPS-1-i];
            product[i] = preSum[i] * $signed(FIR_COEFS[i]);
        end
    end

    always_comb begin
        accSum = '0;
        for (int i = 0; i < HALF_TAPS; i++) begin
            accSum = accSum + product[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            delayLine <= '{default: '0};
        end
        else if (clkEn) begin
            if (clear) begin
                delayLine <= '{default: '0};
            end
            else if (sampleEn) begin
                for (int i = 0; i < NUM_TAPS-1; i++) begin
                    delayLine[i] <= nextTaps[i];
                end
            end
        end
    end

    // sum registers together with its valid on the shift edge
    always_ff @(posedge clk) begin
        if (reset) begin
            filtOut <= '0;
        end
        else if (clkEn) begin
            filtOut.valid <= sampleEn;
            if (clear) begin
                filtOut.sample <= '0;
            end
            else if (sampleEn) begin
                filtOut.sample <= accSum;
            end
        end
    end

    // valid only ever rises behind an enabled shift
    assert property (@(posedge clk) disable iff (reset)
        $rose(filtOut.valid) |-> $past(clkEn && sampleEn));

endmodule

//--- hdl/soqpskChannel.sv
`timescale 1ns/100ps

module soqpskChannel (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  logic                posEdgeModClkEn,
    input  logic                modSampleEn,
    input  logic                modData,
    input  logic                modDataValid,
    output soqpskPkg::chanOut_t chanOut
);
    import soqpskPkg::*;

    ternSym_t                     symbol;
    logic                         symbolValid;
    logic signed [FREQ_WIDTH-1:0] freqValue;
    // mapper output is fresh and feeds the filter shift
    logic                         freqStrobe;

    soqpskTernaryEncoder u_enc (
        .clk         (clk),
        .reset       (reset),
        .clkEn       (clkEn),
        .bitEn       (posEdgeModClkEn),
        .dataBit     (modData),
        .dataValid   (modDataValid),
        .symbol      (symbol),
        .symbolValid (symbolValid)
    );

    // symbol to frequency held over two samples
    always_ff @(posedge clk) begin
        if (reset) begin
            freqValue  <= '0;
            freqStrobe <= 1'b0;
        end
        else if (clkEn) begin
            freqStrobe <= modSampleEn;
            if (!modDataValid) begin
                freqValue <= '0;
            end
            else if (modSampleEn) begin
                if (!symbolValid) begin
                    freqValue <= '0;
                end
                else begin
                    case (symbol)
                        SYM_POS: freqValue <= FREQ_HALF;
                        SYM_NEG: freqValue <= -FREQ_HALF;
                        default: freqValue <= '0;
                    endcase
                end
            end
        end
    end

    soqpskShapingFir u_fir (
        .clk      (clk),
        .reset    (reset),
        .clkEn    (clkEn),
        .sampleEn (freqStrobe),
        .clear    (!modDataValid),
        .sampleIn (freqValue),
        .filtOut  (chanOut)
    );

endmodule

//--- hdl/deviationCombiner.sv
`timescale 1ns/100ps

module deviationCombiner (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  logic                modDataValid,
    input  soqpskPkg::chanOut_t chan0,
    input  soqpskPkg::chanOut_t chan1,
    output soqpskPkg::devPair_t deviation,
    output logic                deviationClkEn
);
    import soqpskPkg::*;

    localparam int WIDE_WIDTH = FIR_WIDTH + DEV_GAIN_SHIFT;

    logic pairValid;

    // gain shift clipped to the deviation range
    function automatic logic signed [DEV_WIDTH-1:0] applyGain(
        input logic signed [FIR_WIDTH-1:0] sample
    );
        logic signed [WIDE_WIDTH-1:0] wide;
        wide = sample;
        wide = wide <<< DEV_GAIN_SHIFT;
        if (wide > DEV_MAX) begin
            return DEV_MAX;
        end
        else if (wide < DEV_MIN) begin
            return DEV_MIN;
        end
        return wide[DEV_WIDTH-1:0];
    endfunction

    assign pairValid = chan0.valid && chan1.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            deviation      <= '0;
            deviationClkEn <= 1'b0;
        end
        else if (clkEn) begin
            // strobe keeps running while data is absent
            deviationClkEn <= pairValid;
            if (!modDataValid) begin
                deviation <= '0;
            end
            else if (pairValid) begin
                deviation.dev0 <= applyGain(chan0.sample);
                deviation.dev1 <= applyGain(chan1.sample);
            end
        end
    end

    // both channels share strobes so their outputs stay in lockstep
    assert property (@(posedge clk) disable iff (reset)
        chan0.valid == chan1.valid);

endmodule

//--- hdl/dualSoqpskMod.sv
`timescale 1ns/100ps

module dualSoqpskMod (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  logic                posEdgeModClkEn,
    input  logic                modSampleEn,
    input  logic                modData0,
    input  logic                modData1,
    input  logic                modDataValid,
    output soqpskPkg::devPair_t deviation,
    output logic                deviationClkEn
);
    import soqpskPkg::*;

    chanOut_t chan0Out;
    chanOut_t chan1Out;

    soqpskChannel u_chan0 (
        .clk             (clk),
        .reset           (reset),
        .clkEn           (clkEn),
        .posEdgeModClkEn (posEdgeModClkEn),
        .modSampleEn     (modSampleEn),
        .modData         (modData0),
        .modDataValid    (modDataValid),
        .chanOut         (chan0Out)
    );

    soqpskChannel u_chan1 (
        .clk             (clk),
        .reset           (reset),
        .clkEn           (clkEn),
        .posEdgeModClkEn (posEdgeModClkEn),
        .modSampleEn     (modSampleEn),
        .modData         (modData1),
        .modDataValid    (modDataValid),
        .chanOut         (chan1Out)
    );

    // gain, saturation and the shared output strobe
    deviationCombiner u_comb (
        .clk            (clk),
        .reset          (reset),
        .clkEn          (clkEn),
        .modDataValid   (modDataValid),
        .chan0          (chan0Out),
        .chan1          (chan1Out),
        .deviation      (deviation),
        .deviationClkEn (deviationClkEn)
    );

endmodule

//--- dv/soqpskRefModel.svh
localparam int REF_DEV_MAX = (1 << (DEV_WIDTH - 1)) - 1;
localparam int REF_DEV_MIN = -(1 << (DEV_WIDTH - 1));

// channel state with bits held as +1 or -1
int refPrev1 [2];
int refPrev2 [2];
int refSym   [2];
int refTaps  [2][NUM_TAPS];
int refBitIdx;
bit refSymValid;

// (-1)^(k+1) * b[k-1] * (b[k] - b[k-2]) / 2
function automatic int precodeSymbol(input int k, input int bk, input int bk1, input int bk2);
    int sign;
    sign = (k % 2 == 0) ? -1 : 1;
    return sign * bk1 * (bk - bk2) / 2;
endfunction

// one half is 2 in quarter steps
function automatic int mapFrequency(input bit symValid, input int sym);
    if (!symValid) begin
        return 0;
    end
    return 2 * sym;
endfunction

function automatic int firResponse(input int ch);
    int acc;
    acc = 0;
    for (int i = 0; i < NUM_TAPS; i++) begin
        acc += int'($signed(FIR_COEFS[i])) * refTaps[ch][i];
    end
    return acc;
endfunction

function automatic logic signed [DEV_WIDTH-1:0] saturateGain(input int sum);
    int scaled;
    scaled = sum * (1 << DEV_GAIN_SHIFT);
    if (scaled > REF_DEV_MAX) begin
        scaled = REF_DEV_MAX;
    end
    else if (scaled < REF_DEV_MIN) begin
        scaled = REF_DEV_MIN;
    end
    return scaled[DEV_WIDTH-1:0];
endfunction

// back to bit 0 with +1 history and an empty delay line
function automatic void restartModel();
    refBitIdx   = 0;
    refSymValid = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
        refPrev1[ch] = 1;
        refPrev2[ch] = 1;
        refSym[ch]   = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            refTaps[ch][i] = 0;
        end
    end
endfunction

// the mapper sees the symbol of the previous bit strobe
function automatic devPair_t modelSample(input bit valid, input bit bitStrobe,
                                         input bit d0, input bit d1);
    devPair_t pair;
    int       b;
    pair = '0;
    if (!valid) begin
        restartModel();
        return pair;
    end
    for (int ch = 0; ch < 2; ch++) begin
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            refTaps[ch][i] = refTaps[ch][i-1];
        end
        refTaps[ch][0] = mapFrequency(refSymValid, refSym[ch]);
    end
    pair.dev0 = saturateGain(firResponse(0));
    pair.dev1 = saturateGain(firResponse(1));
    if (bitStrobe) begin
        for (int ch = 0; ch < 2; ch++) begin
            b            = ((ch == 0) ? d0 : d1) ? 1 : -1;
            refSym[ch]   = precodeSymbol(refBitIdx, b, refPrev1[ch], refPrev2[ch]);
            refPrev2[ch] = refPrev1[ch];
            refPrev1[ch] = b;
        end
        refSymValid = 1'b1;
        refBitIdx++;
    end
    return pair;
endfunction

//--- dv/dualSoqpskModTb.sv
`timescale 1ns/100ps

module dualSoqpskModTb;
    import soqpskPkg::*;

    logic     clk;
    logic     reset;
    logic     clkEn;
    logic     posEdgeModClkEn;
    logic     modSampleEn;
    logic     modData0;
    logic     modData1;
    logic     modDataValid;
    devPair_t deviation;
    logic     deviationClkEn;

    devPair_t expQ [$];
    devPair_t expected;
    devPair_t lastDev;
    int       errorCount = 0;
    int       pairCount = 0;
    int       satHigh = 0;
    int       satLow = 0;
    // percent of cycles with clkEn low
    int       lowPct = 0;
    bit       validNow = 1'b0;
    bit       validTarget = 1'b0;

    `include "soqpskRefModel.svh"

    dualSoqpskMod u_dut (
        .clk             (clk),
        .reset           (reset),
        .clkEn           (clkEn),
        .posEdgeModClkEn (posEdgeModClkEn),
        .modSampleEn     (modSampleEn),
        .modData0        (modData0),
        .modData1        (modData1),
        .modDataValid    (modDataValid),
        .deviation       (deviation),
        .deviationClkEn  (deviationClkEn)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic bit randomBit();
        return $urandom_range(1) == 1;
    endfunction

    // inserts at most 3 disabled cycles in a row
    task automatic driveEnabledCycle(input bit bitStrobe, input bit sampleStrobe,
                                     input bit validPhase, input bit d0, input bit d1);
        int idle;
        bit en;
        idle = 0;
        en   = 1'b0;
        while (!en) begin
            @(posedge clk);
            en = (idle >= 3) || ($urandom_range(99) >= lowPct);
            idle++;
            clkEn           <= en;
            posEdgeModClkEn <= en && bitStrobe;
            modSampleEn     <= en && sampleStrobe;
        end
        if (bitStrobe) begin
            modData0 <= d0;
            modData1 <= d1;
        end
        // valid only moves while no sample is in flight
        if (validPhase && validTarget != validNow) begin
            validNow     = validTarget;
            modDataValid <= validTarget;
            if (validTarget) begin
                restartModel();
            end
        end
        if (sampleStrobe) begin
            expQ.push_back(modelSample(validNow, bitStrobe, d0, d1));
        end
    endtask

    // 12 enabled cycles with samples at 0 and 6
    task automatic sendBit(input bit d0, input bit d1);
        for (int ph = 0; ph < 12; ph++) begin
            driveEnabledCycle(ph == 0, ph == 0 || ph == 6, ph == 3, d0, d1);
        end
    endtask

    task automatic reportAndFinish();
        assert (expQ.size() == 0) else begin
            errorCount++;
            $display("%0d expected deviation pairs were never produced", expQ.size());
        end
        $display("Pairs checked: %0d, errors: %0d", pairCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic waitForPairs();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            errorCount++;
            $display("Timed out waiting for the DUT to deliver its deviation pairs");
        end
    endtask

    // a pair is taken on the enabled cycle of its strobe
    always @(negedge clk) begin
        if (!reset && clkEn && deviationClkEn) begin
            assert (expQ.size() != 0) else begin
                errorCount++;
                $display("Deviation strobe at %0t with no sample outstanding", $time);
            end
            if (expQ.size() != 0) begin
                expected = expQ.pop_front();
                pairCount++;
                lastDev = deviation;
                assert (deviation == expected) else begin
                    errorCount++;
                    $display("FAILED at %0t: deviation (%0d, %0d), expected (%0d, %0d)",
                             $time, deviation.dev0, deviation.dev1,
                             expected.dev0, expected.dev1);
                end
                if (deviation.dev0 == REF_DEV_MAX || deviation.dev1 == REF_DEV_MAX) begin
                    satHigh++;
                end
                if (deviation.dev0 == REF_DEV_MIN || deviation.dev1 == REF_DEV_MIN) begin
                    satLow++;
                end
            end
        end
    end

    initial begin
        void'($urandom(38083));
        reset           = 1'b1;
        clkEn           = 1'b1;
        posEdgeModClkEn = 1'b0;
        modSampleEn     = 1'b0;
        modData0        = 1'b0;
        modData1        = 1'b0;
        modDataValid    = 1'b0;
        restartModel();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // quiet output before any sample strobe
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            assert (!deviationClkEn && deviation == '0) else begin
                errorCount++;
                $display("FAILED at %0t: output active before the first sample strobe", $time);
            end
        end
        sendBit(1'b0, 1'b0);
        sendBit(1'b1, 1'b0);

        validTarget = 1'b1;
        for (int k = 0; k < 40; k++) begin
            sendBit(k[0], randomBit());
        end

        // zero symbols after two ones let the filter settle
        for (int k = 0; k < 24; k++) begin
            sendBit(1'b1, 1'b1);
        end
        waitForPairs();
        assert (lastDev == '0) else begin
            errorCount++;
            $display("FAILED at %0t: deviation (%0d, %0d) did not settle to zero",
                     $time, lastDev.dev0, lastDev.dev1);
        end

        lowPct = 33;
        for (int k = 0; k < 60; k++) begin
            sendBit(randomBit(), randomBit());
        end
        lowPct = 0;

        validTarget = 1'b0;
        for (int k = 0; k < 3; k++) begin
            sendBit(randomBit(), randomBit());
        end
        validTarget = 1'b1;
        for (int k = 0; k < 12; k++) begin
            sendBit(randomBit(), randomBit());
        end

        // restart and hold one polarity per channel
        validTarget = 1'b0;
        sendBit(1'b0, 1'b0);
        validTarget = 1'b1;
        sendBit(1'b0, 1'b0);
        satHigh = 0;
        satLow  = 0;
        for (int k = 0; k < 24; k++) begin
            sendBit(k[1], (k == 0) || !((k + 1) & 2));
        end
        waitForPairs();
        assert (satHigh > 0 && satLow > 0) else begin
            errorCount++;
            $display("Deviation never reached both saturation limits");
        end
        reportAndFinish();
    end

endmodule

//--- dualSoqpsk.f
+incdir+dv
hdl/soqpskPkg.sv
hdl/soqpskTernaryEncoder.sv
hdl/soqpskShapingFir.sv
hdl/soqpskChannel.sv
hdl/deviationCombiner.sv
hdl/dualSoqpskMod.sv
dv/dualSoqpskModTb.sv

//--- Makefile
SIM  = obj_dir/VdualSoqpskModTb
SRCS = $(wildcard hdl/*.sv dv/*.sv dv/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) dualSoqpsk.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module dualSoqpskModTb -f dualSoqpsk.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
